//--- files.f
+incdir+.
regstage_pkg.sv
decode_intake.sv
gpr_file.sv
csr_unit.sv
operand_issue.sv
reg_stage_top.sv
tb_clock_gen.sv
reg_stage_assertions.sv
reg_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the register stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  -f files.f --top-module reg_stage_tb -Mdir "$OBJ_DIR" -o reg_stage_sim \
  > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status, see $BUILD_LOG"
  exit 1
fi

"./$OBJ_DIR/reg_stage_sim" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation stopped with status $status, see $SIM_LOG"
  exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
exit 0

//--- reg_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "regstage_defines.svh"

module reg_stage_tb import regstage_pkg::*; ();

  localparam int NUM_FIXED      = 20;
  localparam int NUM_RAND       = 8;
  localparam int NUM_CMDS       = NUM_FIXED + NUM_RAND;
  localparam int WORST_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 4 + NUM_CMDS * WORST_CYCLES + 40;

  typedef struct packed {
    rs_bundle_t          bundle;
    logic [`RS_XLEN-1:0] mtvec;
    logic [`RS_XLEN-1:0] mepc;
    logic [`RS_XLEN-1:0] mstatus;
    logic [`RS_XLEN-1:0] mcause;
  } expect_t;

  logic                clk;
  logic                rst;
  logic                dec_req;
  rs_cmd_t             dec_cmd;
  logic                dec_ack;
  logic                exe_req;
  logic                exe_ack;
  rs_bundle_t          exe_bundle;
  logic [`RS_XLEN-1:0] mtvec;
  logic [`RS_XLEN-1:0] mepc;
  logic [`RS_XLEN-1:0] mstatus;
  logic [`RS_XLEN-1:0] mcause;

  rs_cmd_t             cmd_table [NUM_CMDS];
  expect_t             exp_q [$];
  logic [15:0]         lfsr_state = 16'd55588;
  logic [`RS_XLEN-1:0] ref_gpr [`RS_NUM_GPR];
  logic [`RS_XLEN-1:0] ref_mtvec;
  logic [`RS_XLEN-1:0] ref_mepc;
  logic [`RS_XLEN-1:0] ref_mstatus;
  logic [`RS_XLEN-1:0] ref_mcause;
  int                  bundle_errors;
  int                  word_errors;
  int                  bundle_count;

  tb_clock_gen clock_i (
    .clk (clk),
    .rst (rst)
  );

  reg_stage_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .dec_req    (dec_req),
    .dec_cmd    (dec_cmd),
    .exe_ack    (exe_ack),
    .dec_ack    (dec_ack),
    .exe_req    (exe_req),
    .exe_bundle (exe_bundle),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .mstatus    (mstatus),
    .mcause     (mcause)
  );

  bind reg_stage_top reg_stage_assertions assertions_i (
    .clk        (clk),
    .rst        (rst),
    .dec_req    (dec_req),
    .dec_ack    (dec_ack),
    .exe_req    (exe_req),
    .exe_ack    (exe_ack),
    .exe_bundle (exe_bundle)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random bits and stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // taps 16, 14, 13, 11 give a maximal length sequence.
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic rs_cmd_t make_cmd(input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [4:0] rd, input logic wb_en,
                                       input logic [31:0] wb_data, input csr_sel_t sel,
                                       input logic csr_wen, input logic [31:0] csr_wdata);
    rs_cmd_t c;
    c           = '0;
    c.rs1       = rs1;
    c.rs2       = rs2;
    c.rd        = rd;
    c.wb_en     = wb_en;
    c.wb_data   = wb_data;
    c.csr_sel   = sel;
    c.csr_wen   = csr_wen;
    c.csr_wdata = csr_wdata;
    return c;
  endfunction

  function automatic void fill_table();
    cmd_table[0]  = make_cmd(5'd1, 5'd2, 5'd1, 1'b1, 32'ha5a5_0001, CSR_MSTATUS, 1'b0, 32'h0);
    cmd_table[1]  = make_cmd(5'd1, 5'd2, 5'd2, 1'b1, 32'h1234_5678, CSR_MCAUSE, 1'b0, 32'h0);
    cmd_table[2]  = make_cmd(5'd2, 5'd1, 5'd2, 1'b1, 32'hdead_beef, CSR_NONE, 1'b0, 32'h0);
    cmd_table[3]  = make_cmd(5'd2, 5'd0, 5'd0, 1'b1, 32'hffff_ffff, CSR_NONE, 1'b0, 32'h0);
    cmd_table[4]  = make_cmd(5'd0, 5'd16, 5'd16, 1'b1, 32'h5555_5555, CSR_NONE, 1'b0, 32'h0);
    cmd_table[5]  = make_cmd(5'd0, 5'd15, 5'd15, 1'b1, 32'h0f0f_0f0f, CSR_NONE, 1'b0, 32'h0);
    cmd_table[6]  = make_cmd(5'd15, 5'd1, 5'd3, 1'b0, 32'h7777_7777, CSR_MTVEC, 1'b1, 32'h400);
    cmd_table[7]  = make_cmd(5'd3, 5'd15, 5'd4, 1'b1, 32'h44, CSR_MTVEC, 1'b1, 32'h800);
    cmd_table[8]  = make_cmd(5'd4, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MTVEC, 1'b0, 32'h0);
    cmd_table[9]  = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MEPC, 1'b1, 32'h2000);
    cmd_table[10] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MEPC, 1'b0, 32'h0);
    cmd_table[11] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MCAUSE, 1'b1, 32'h7);
    cmd_table[12] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MCAUSE, 1'b0, 32'h0);
    cmd_table[13] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MSTATUS, 1'b1, 32'h1880);
    cmd_table[14] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MSTATUS, 1'b0, 32'h0);
    cmd_table[15] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MSTATUS, 1'b1, 32'h8);
    cmd_table[16] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MSTATUS, 1'b0, 32'h0);
    cmd_table[17] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MTVEC, 1'b1, 32'hffff_0000);
    cmd_table[18] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MEPC, 1'b0, 32'h0);
    cmd_table[19] = make_cmd(5'd0, 5'd0, 5'd0, 1'b0, 32'h0, CSR_MCAUSE, 1'b0, 32'h0);
    cmd_table[14].mret  = 1'b1;
    cmd_table[16].mret  = 1'b1;
    cmd_table[17].ecall = 1'b1;
    for (int i = NUM_FIXED; i < NUM_CMDS; i++) begin
      cmd_table[i] = make_cmd(5'(random_bits(5)), 5'(random_bits(5)), 5'(random_bits(5)),
                              lfsr_bit(), random_bits(32),
                              csr_sel_t'(3'(random_bits(2)) + 3'd1), lfsr_bit(),
                              random_bits(32));
    end
    for (int i = 0; i < NUM_CMDS; i++) begin
      cmd_table[i].pc = 32'h0000_0100 + 32'(i) * 32'd4;
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] ref_read(input logic [4:0] idx);
    return (idx < 5'd16) ? ref_gpr[idx[3:0]] : 32'h0;
  endfunction

  function automatic logic [31:0] ref_csr(input csr_sel_t sel);
    case (sel)
      CSR_MTVEC:   return ref_mtvec;
      CSR_MEPC:    return ref_mepc;
      CSR_MSTATUS: return ref_mstatus;
      CSR_MCAUSE:  return ref_mcause;
      default:     return 32'h0;
    endcase
  endfunction

  // the bundle sees the state before the command, the CSR outputs the state after it.
  function automatic expect_t predict(input rs_cmd_t c);
    expect_t e;
    e.bundle.src1      = ref_read(c.rs1);
    e.bundle.src2      = ref_read(c.rs2);
    e.bundle.csr_rdata = ref_csr(c.csr_sel);
    e.bundle.mtvec     = ref_mtvec;
    e.bundle.mepc      = ref_mepc;
    if (c.wb_en && c.rd != 5'd0 && c.rd < 5'd16) begin
      ref_gpr[c.rd[3:0]] = c.wb_data;
    end
    if (c.ecall) begin
      ref_mepc    = c.pc;
      ref_mcause  = 32'd11;
      ref_mstatus = 32'h0000_1800;
    end else if (c.mret) begin
      // mie takes mpie, mpie is set and mpp falls to zero.
      ref_mstatus = (ref_mstatus & ~32'h0000_1888) | ((ref_mstatus >> 4) & 32'h8) | 32'h80;
    end else if (c.csr_wen) begin
      case (c.csr_sel)
        CSR_MTVEC:   ref_mtvec   = c.csr_wdata;
        CSR_MEPC:    ref_mepc    = c.csr_wdata;
        CSR_MSTATUS: ref_mstatus = c.csr_wdata;
        CSR_MCAUSE:  ref_mcause  = c.csr_wdata;
        default:     ;
      endcase
    end
    e.mtvec   = ref_mtvec;
    e.mepc    = ref_mepc;
    e.mstatus = ref_mstatus;
    e.mcause  = ref_mcause;
    return e;
  endfunction

  task automatic check_bundle(input rs_bundle_t got, input rs_bundle_t exp, input int idx);
    if (got !== exp) begin
      bundle_errors++;
      $display("ERROR %0t: command %0d bundle is %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string name, input int idx);
    if (got !== exp) begin
      word_errors++;
      $display("ERROR %0t: after command %0d %s is %h, expected %h",
               $time, idx, name, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode side and run control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : decode_side
    dec_req       = 1'b0;
    dec_cmd       = '0;
    bundle_errors = 0;
    word_errors   = 0;
    bundle_count  = 0;
    ref_mtvec     = 32'h0;
    ref_mepc      = 32'h0;
    ref_mstatus   = 32'h0000_1800;
    ref_mcause    = 32'h0;
    for (int i = 0; i < `RS_NUM_GPR; i++) begin
      ref_gpr[i] = 32'h0;
    end
    fill_table();
    for (int i = 0; i < NUM_CMDS; i++) begin
      exp_q.push_back(predict(cmd_table[i]));
    end
    @(negedge rst);
    @(posedge clk);
    check_word(mtvec, 32'h0, "mtvec", -1);
    check_word(mepc, 32'h0, "mepc", -1);
    check_word(mstatus, 32'h0000_1800, "mstatus", -1);
    check_word(mcause, 32'h0, "mcause", -1);
    for (int i = 0; i < NUM_CMDS; i++) begin
      @(posedge clk);
      dec_cmd <= cmd_table[i];
      dec_req <= 1'b1;
      do @(posedge clk); while (!dec_ack);
      dec_req <= 1'b0;
      do @(posedge clk); while (dec_ack);
    end
    wait (bundle_count == NUM_CMDS);
    repeat (8) @(posedge clk);
    if (exe_req) begin
      bundle_errors++;
      $display("an extra bundle was issued after the last command");
    end
    $display("errors: %0d bundle, %0d csr word; %0d of %0d bundles seen",
             bundle_errors, word_errors, bundle_count, NUM_CMDS);
    if (bundle_errors + word_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // execute answers each request after 0 to 3 cycles.
  initial begin : execute_side
    int      n;
    int      delay;
    expect_t e;
    n       = 0;
    exe_ack = 1'b0;
    forever begin
      @(posedge clk);
      if (exe_req && !exe_ack) begin
        delay = int'(random_bits(2));
        repeat (delay) @(posedge clk);
        if (exp_q.size() == 0) begin
          bundle_errors++;
          $display("a bundle arrived at %0t with no command left to match it", $time);
        end else begin
          e = exp_q.pop_front();
          check_bundle(exe_bundle, e.bundle, n);
          check_word(mtvec, e.mtvec, "mtvec", n);
          check_word(mepc, e.mepc, "mepc", n);
          check_word(mstatus, e.mstatus, "mstatus", n);
          check_word(mcause, e.mcause, "mcause", n);
        end
        n++;
        bundle_count = n;
        exe_ack <= 1'b1;
        do @(posedge clk); while (exe_req);
        exe_ack <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run did not finish in %0d cycles, %0d of %0d bundles seen",
             TIMEOUT_CYCLES, bundle_count, NUM_CMDS);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- reg_stage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module reg_stage_assertions import regstage_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       dec_req,
  input logic       dec_ack,
  input logic       exe_req,
  input logic       exe_ack,
  input rs_bundle_t exe_bundle
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // four-phase handshakes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  ack_needs_req: assert property (
    @(posedge clk) disable iff (rst) $rose(dec_ack) |-> dec_req
  ) else $error("dec_ack rose while dec_req was low");

  // execute may sample the bundle at any point before it acks.
  bundle_held: assert property (
    @(posedge clk) disable iff (rst) (exe_req && !exe_ack) |=> $stable(exe_bundle)
  ) else $error("exe_bundle changed while exe_req waited for exe_ack");

  req_low_in_reset: assert property (
    @(posedge clk) rst |-> !exe_req
  ) else $error("exe_req was high during reset");

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- reg_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "regstage_defines.svh"

module reg_stage_top import regstage_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                dec_req,
  input  rs_cmd_t             dec_cmd,
  input  logic                exe_ack,
  output logic                dec_ack,
  output logic                exe_req,
  output rs_bundle_t          exe_bundle,
  output logic [`RS_XLEN-1:0] mtvec,
  output logic [`RS_XLEN-1:0] mepc,
  output logic [`RS_XLEN-1:0] mstatus,
  output logic [`RS_XLEN-1:0] mcause
);

  logic                slot_valid;
  rs_cmd_t             slot_cmd;
  logic                take;
  logic                gpr_wen;
  logic [`RS_XLEN-1:0] src1;
  logic [`RS_XLEN-1:0] src2;
  logic [`RS_XLEN-1:0] csr_rdata;

  // take loads the bundle and commits the writes on the same edge.
  assign gpr_wen = take && slot_cmd.wb_en;

  decode_intake intake_i (
    .clk        (clk),
    .rst        (rst),
    .dec_req    (dec_req),
    .dec_cmd    (dec_cmd),
    .take       (take),
    .dec_ack    (dec_ack),
    .slot_valid (slot_valid),
    .slot_cmd   (slot_cmd)
  );

  gpr_file gpr_i (
    .clk    (clk),
    .rst    (rst),
    .rs1    (slot_cmd.rs1),
    .rs2    (slot_cmd.rs2),
    .rd     (slot_cmd.rd),
    .wen    (gpr_wen),
    .wdata  (slot_cmd.wb_data),
    .rdata1 (src1),
    .rdata2 (src2)
  );

  csr_unit csr_i (
    .clk       (clk),
    .rst       (rst),
    .commit    (take),
    .pc        (slot_cmd.pc),
    .csr_sel   (slot_cmd.csr_sel),
    .csr_wen   (slot_cmd.csr_wen),
    .csr_wdata (slot_cmd.csr_wdata),
    .ecall     (slot_cmd.ecall),
    .mret      (slot_cmd.mret),
    .csr_rdata (csr_rdata),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .mstatus   (mstatus),
    .mcause    (mcause)
  );

  operand_issue issue_i (
    .clk        (clk),
    .rst        (rst),
    .slot_valid (slot_valid),
    .src1       (src1),
    .src2       (src2),
    .csr_rdata  (csr_rdata),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .exe_ack    (exe_ack),
    .take       (take),
    .exe_req    (exe_req),
    .exe_bundle (exe_bundle)
  );

endmodule

`default_nettype wire

//--- operand_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "regstage_defines.svh"

module operand_issue import regstage_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                slot_valid,
  input  logic [`RS_XLEN-1:0] src1,
  input  logic [`RS_XLEN-1:0] src2,
  input  logic [`RS_XLEN-1:0] csr_rdata,
  input  logic [`RS_XLEN-1:0] mtvec,
  input  logic [`RS_XLEN-1:0] mepc,
  input  logic                exe_ack,
  output logic                take,
  output logic                exe_req,
  output rs_bundle_t          exe_bundle
);

  // the bundle stays held through ST_DRAIN until execute drops its ack.
  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_REQ,
    ST_DRAIN
  } state_t;

  state_t state;

  assign take = (state == ST_EMPTY) && slot_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_EMPTY;
    end else begin
      case (state)
        ST_EMPTY: if (take) state <= ST_REQ;
        ST_REQ:   if (exe_ack) state <= ST_DRAIN;
        ST_DRAIN: if (!exe_ack) state <= ST_EMPTY;
        default:  state <= ST_EMPTY;
      endcase
    end
  end

  // sources are sampled before this command's own writes land.
  always_ff @(posedge clk) begin
    if (take) begin
      exe_bundle.src1      <= src1;
      exe_bundle.src2      <= src2;
      exe_bundle.csr_rdata <= csr_rdata;
      exe_bundle.mtvec     <= mtvec;
      exe_bundle.mepc      <= mepc;
    end
  end

  assign exe_req = (state == ST_REQ);

endmodule

`default_nettype wire

//--- csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "regstage_defines.svh"

module csr_unit import regstage_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                commit,
  input  logic [`RS_XLEN-1:0] pc,
  input  csr_sel_t            csr_sel,
  input  logic                csr_wen,
  input  logic [`RS_XLEN-1:0] csr_wdata,
  input  logic                ecall,
  input  logic                mret,
  output logic [`RS_XLEN-1:0] csr_rdata,
  output logic [`RS_XLEN-1:0] mtvec,
  output logic [`RS_XLEN-1:0] mepc,
  output logic [`RS_XLEN-1:0] mstatus,
  output logic [`RS_XLEN-1:0] mcause
);

  mstatus_u mstatus_q;
  mstatus_u mstatus_mret;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // trap return
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    mstatus_mret        = mstatus_q;
    mstatus_mret.f.mie  = mstatus_q.f.mpie;
    mstatus_mret.f.mpie = 1'b1;
    mstatus_mret.f.mpp  = 2'b00;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // update on commit
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // ecall wins over mret, and either wins over a plain CSR write.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mtvec         <= '0;
      mepc          <= '0;
      mstatus_q.raw <= `RS_MSTATUS_RESET;
      mcause        <= '0;
    end else if (commit) begin
      if (ecall) begin
        mepc          <= pc;
        mcause        <= `RS_ECALL_CAUSE;
        mstatus_q.raw <= `RS_MSTATUS_RESET;
      end else if (mret) begin
        mstatus_q <= mstatus_mret;
      end else if (csr_wen) begin
        case (csr_sel)
          CSR_MTVEC:   mtvec         <= csr_wdata;
          CSR_MEPC:    mepc          <= csr_wdata;
          CSR_MSTATUS: mstatus_q.raw <= csr_wdata;
          CSR_MCAUSE:  mcause        <= csr_wdata;
          default:     ;
        endcase
      end
    end
  end

  always_comb begin
    case (csr_sel)
      CSR_MTVEC:   csr_rdata = mtvec;
      CSR_MEPC:    csr_rdata = mepc;
      CSR_MSTATUS: csr_rdata = mstatus_q.raw;
      CSR_MCAUSE:  csr_rdata = mcause;
      default:     csr_rdata = '0;
    endcase
  end

  assign mstatus = mstatus_q.raw;

endmodule

`default_nettype wire

//--- gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "regstage_defines.svh"

module gpr_file (
  input  logic                clk,
  input  logic                rst,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  input  logic [4:0]          rd,
  input  logic                wen,
  input  logic [`RS_XLEN-1:0] wdata,
  output logic [`RS_XLEN-1:0] rdata1,
  output logic [`RS_XLEN-1:0] rdata2
);

  localparam int IDX_W = $clog2(`RS_NUM_GPR);

  logic [`RS_XLEN-1:0] regs [`RS_NUM_GPR];
  logic                wr_ok;

  // rv32e has no x16 and up, so those writes are dropped.
  assign wr_ok = wen && (rd != 5'd0) && (rd < 5'(`RS_NUM_GPR));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RS_NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[rd[IDX_W-1:0]] <= wdata;
    end
  end

  // x0 is never written, so it reads zero without a special case.
  assign rdata1 = (rs1 < 5'(`RS_NUM_GPR)) ? regs[rs1[IDX_W-1:0]] : '0;
  assign rdata2 = (rs2 < 5'(`RS_NUM_GPR)) ? regs[rs2[IDX_W-1:0]] : '0;

endmodule

`default_nettype wire

//--- decode_intake.sv
`timescale 1ns/1ps
`default_nettype none

module decode_intake import regstage_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    dec_req,
  input  rs_cmd_t dec_cmd,
  input  logic    take,
  output logic    dec_ack,
  output logic    slot_valid,
  output rs_cmd_t slot_cmd
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_t;

  state_t state;
  logic   accept;

  // a new request is only taken once the last ack has dropped and the slot is free.
  assign accept = (state == ST_IDLE) && dec_req && !slot_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!dec_req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // accept and take never meet, since take needs a full slot.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_valid <= 1'b0;
    end else if (accept) begin
      slot_valid <= 1'b1;
    end else if (take) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      slot_cmd <= dec_cmd;
    end
  end

  assign dec_ack = (state == ST_ACK);

endmodule

`default_nettype wire

//--- regstage_pkg.sv
`default_nettype none

`include "regstage_defines.svh"

package regstage_pkg;

  // small select code in place of the 12-bit CSR address.
  typedef enum logic [2:0] {
    CSR_NONE    = 3'd0,
    CSR_MTVEC   = 3'd1,
    CSR_MEPC    = 3'd2,
    CSR_MSTATUS = 3'd3,
    CSR_MCAUSE  = 3'd4
  } csr_sel_t;

  typedef struct packed {
    logic [`RS_XLEN-1:0] pc;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic                wb_en;
    logic [`RS_XLEN-1:0] wb_data;
    csr_sel_t            csr_sel;
    logic                csr_wen;
    logic [`RS_XLEN-1:0] csr_wdata;
    logic                ecall;
    logic                mret;
  } rs_cmd_t;

  typedef struct packed {
    logic [`RS_XLEN-1:0] src1;
    logic [`RS_XLEN-1:0] src2;
    logic [`RS_XLEN-1:0] csr_rdata;
    logic [`RS_XLEN-1:0] mtvec;
    logic [`RS_XLEN-1:0] mepc;
  } rs_bundle_t;

  typedef struct packed {
    logic [18:0] pad_hi;
    logic [1:0]  mpp;
    logic [2:0]  pad_mid;
    logic        mpie;
    logic [2:0]  pad_lo;
    logic        mie;
    logic [2:0]  pad_low;
  } mstatus_fields_t;

  // mstatus seen as a raw word or by its named fields.
  typedef union packed {
    logic [`RS_XLEN-1:0] raw;
    mstatus_fields_t     f;
  } mstatus_u;

endpackage

`default_nettype wire

//--- regstage_defines.svh
`ifndef REGSTAGE_DEFINES_SVH
`define REGSTAGE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define RS_XLEN     32
`define RS_NUM_GPR  16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine CSR constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// mpp is machine mode, interrupts disabled.
`define RS_MSTATUS_RESET  32'h0000_1800
`define RS_ECALL_CAUSE    32'd11

`endif
